/* Makefile */
# Verilator build and run of the MMU testbench
SRCS := $(shell grep -v '^+' sources.f)

obj_dir/mmu_tb: sources.f $(SRCS) $(wildcard logic/*.svh)
	verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f \
		--top-module mmu_tb -Mdir obj_dir -o mmu_tb

run: obj_dir/mmu_tb
	@out=$$(./obj_dir/mmu_tb 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* logic/mmu_consts.svh */
// Fixed MMU sizes; widths must stay consistent (LA = IDX + OFS, PA = PPN + OFS)
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// Logical side
`define MMU_LA_W      16  // Logical address bits
`define MMU_OFS_W     10  // Byte offset within a page
`define MMU_IDX_W     6   // Page table index
`define MMU_PAGES     64  // Page table entries

// Physical side
`define MMU_PPN_W     14  // Physical page number
`define MMU_PA_W      24  // Physical address bits

// Configuration port
`define MMU_WB_ADR_W  7   // Wishbone word address
`define MMU_CSR_ADR   64  // Control register, right above the table

`endif

/* logic/mmu_csr.sv */
// Wishbone classic slave; every access takes two cycles, no wait states and no error response
`timescale 1ns/10ps
`include "mmu_consts.svh"

module mmu_csr (
   input  logic                     sysclk,
   input  logic                     rst_n,
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  logic [`MMU_WB_ADR_W-1:0] wb_adr,
   input  logic [15:0]              wb_dat_i,
   output logic [15:0]              wb_dat_o,
   output logic                     wb_ack,
   mmu_cfg_if.csr                   cfg
);

   mmu_pkg::wb_state_e state;
   logic               access;    // Strobe accepted this cycle
   logic               sel_tbl;
   logic               sel_ctl;
   logic [15:0]        rd_next;
   logic [15:0]        rd_data;

   assign access  = wb_cyc & wb_stb & (state == mmu_pkg::WB_IDLE);
   assign sel_tbl = wb_adr < `MMU_WB_ADR_W'(`MMU_PAGES);
   assign sel_ctl = wb_adr == `MMU_WB_ADR_W'(`MMU_CSR_ADR);

   // Slave FSM, ack one cycle after the strobe, then one idle cycle
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         state <= mmu_pkg::WB_IDLE;
      end else begin
         case (state)
            mmu_pkg::WB_IDLE: if (access) state <= mmu_pkg::WB_ACK;
            default:          state <= mmu_pkg::WB_IDLE;
         endcase
      end
   end

   assign wb_ack = (state == mmu_pkg::WB_ACK);

   // Table writes go straight through on the strobe cycle
   assign cfg.tbl_we    = access & wb_we & sel_tbl;
   assign cfg.tbl_idx   = wb_adr[`MMU_IDX_W-1:0];
   assign cfg.tbl_wdata = wb_dat_i;

   // Control register, only the mapping enable exists
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         cfg.map_en <= 1'b0;
      end else if (access && wb_we && sel_ctl) begin
         cfg.map_en <= wb_dat_i[0];
      end
   end

   // Read mux, unmapped addresses give zero
   always_comb begin
      rd_next = 16'h0000;
      if (sel_tbl) begin
         rd_next = cfg.tbl_rdata;
      end else if (sel_ctl) begin
         rd_next = {15'b0, cfg.map_en};
      end
   end

   always_ff @(posedge sysclk) begin
      if (access) begin
         rd_data <= rd_next;  // Shows up together with ack
      end
   end

   assign wb_dat_o = rd_data;

endmodule

/* logic/mmu_if.sv */
// Internal MMU interfaces; no clock inside, all timing is set by the connected modules
`timescale 1ns/10ps
`include "mmu_consts.svh"

// Configuration path from the CSR block to the page table and the checker
interface mmu_cfg_if;
   logic                  tbl_we;     // Table write strobe
   logic [`MMU_IDX_W-1:0] tbl_idx;    // Entry for read and write
   logic [15:0]           tbl_wdata;
   logic [15:0]           tbl_rdata;  // Combinational table read
   logic                  map_en;     // Control register bit 0

   modport csr (
      output tbl_we, tbl_idx, tbl_wdata, map_en,
      input  tbl_rdata
   );

   // Page table side ("table" itself is a reserved word)
   modport tbl (
      input  tbl_we, tbl_idx, tbl_wdata,
      output tbl_rdata
   );

   modport check (
      input map_en
   );
endinterface

// Stage 1 to stage 2 translation data
interface mmu_xlat_if;
   logic                  vld;
   logic                  write;
   logic [`MMU_IDX_W-1:0] idx;    // Page index, needed for pass-through
   logic [`MMU_OFS_W-1:0] ofs;
   mmu_pkg::page_entry_t  entry;

   modport src (output vld, write, idx, ofs, entry);
   modport dst (input  vld, write, idx, ofs, entry);
endinterface

/* logic/mmu_page_table.sv */
// Stage 1 page table lookup; RAM is not cleared by reset, a same-cycle write is seen next cycle
`timescale 1ns/10ps
`include "mmu_consts.svh"

module mmu_page_table (
   input  logic                 sysclk,
   input  logic                 rst_n,
   input  logic                 req_valid,
   input  logic [`MMU_LA_W-1:0] req_addr,
   input  logic                 req_write,
   mmu_cfg_if.tbl               cfg,
   mmu_xlat_if.src              xo
);

   mmu_pkg::page_entry_t        mem [0:`MMU_PAGES-1];
   logic [`MMU_IDX_W-1:0]       req_idx;

   assign req_idx = req_addr[`MMU_LA_W-1:`MMU_OFS_W];

   // Single write port, owned by the configuration side
   always_ff @(posedge sysclk) begin
      if (cfg.tbl_we) begin
         mem[cfg.tbl_idx] <= cfg.tbl_wdata;
      end
   end

   // Configuration read is asynchronous, the CSR registers it
   assign cfg.tbl_rdata = mem[cfg.tbl_idx];

   // Lookup port, old entry wins against a write in the same cycle
   always_ff @(posedge sysclk) begin
      xo.entry <= mem[req_idx];
      xo.idx   <= req_idx;
      xo.ofs   <= req_addr[`MMU_OFS_W-1:0];
      xo.write <= req_write;
   end

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         xo.vld <= 1'b0;
      end else begin
         xo.vld <= req_valid;
      end
   end

endmodule

/* logic/mmu_pkg.sv */
// MMU shared types; entry layout is fixed at 16 bits, a PPN wider than 14 bits will not fit
`include "mmu_consts.svh"

package mmu_pkg;

   // One page table entry as stored in the RAM
   typedef struct packed {
      logic                  valid;     // Bit 15, entry may be used
      logic                  wprot_ok;  // Bit 14, writes are allowed
      logic [`MMU_PPN_W-1:0] ppn;       // Bits 13..0
   } page_entry_t;

   // Translation result reported with every response
   typedef enum logic [1:0] {
      XLAT_OK      = 2'd0,  // Address usable
      XLAT_INVALID = 2'd1,  // Valid bit cleared
      XLAT_WPROT   = 2'd2   // Write to a read-only page
   } xlat_status_e;

   // Wishbone slave state, every access is strobe then ack
   typedef enum logic {
      WB_IDLE = 1'b0,
      WB_ACK  = 1'b1
   } wb_state_e;

endpackage

/* logic/mmu_prot_check.sv */
// Stage 2 protection check; no back-pressure, a response must be taken in the cycle it is valid
`timescale 1ns/10ps
`include "mmu_consts.svh"

module mmu_prot_check (
   input  logic                       sysclk,
   input  logic                       rst_n,
   mmu_xlat_if.dst                    xi,
   mmu_cfg_if.check                   cfg,
   output logic                       rsp_valid,
   output logic [`MMU_PA_W-1:0]       rsp_paddr,
   output mmu_pkg::xlat_status_e      rsp_status
);

   logic [`MMU_PA_W-1:0]  paddr_next;
   mmu_pkg::xlat_status_e status_next;

   always_comb begin
      if (!cfg.map_en) begin
         // Unmapped, logical address zero-extended
         paddr_next  = {{(`MMU_PA_W-`MMU_LA_W){1'b0}}, xi.idx, xi.ofs};
         status_next = mmu_pkg::XLAT_OK;
      end else begin
         paddr_next = {xi.entry.ppn, xi.ofs};  // Formed even on a fault
         if (!xi.entry.valid) begin
            status_next = mmu_pkg::XLAT_INVALID;
         end else if (xi.write && !xi.entry.wprot_ok) begin
            status_next = mmu_pkg::XLAT_WPROT;
         end else begin
            status_next = mmu_pkg::XLAT_OK;
         end
      end
   end

   always_ff @(posedge sysclk) begin
      rsp_paddr  <= paddr_next;
      rsp_status <= status_next;
   end

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= xi.vld;
      end
   end

endmodule

/* logic/mmu_top.sv */
// MMU top level; fixed 2-cycle translation latency, Wishbone slave for configuration only
`timescale 1ns/10ps
`include "mmu_consts.svh"

module mmu_top (
   input  logic                     sysclk,    // System clock
   input  logic                     rst_n,     // Synchronous, active low

   // Wishbone configuration port
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  logic [`MMU_WB_ADR_W-1:0] wb_adr,
   input  logic [15:0]              wb_dat_i,
   output logic [15:0]              wb_dat_o,
   output logic                     wb_ack,

   // Translation request and response
   input  logic                     req_valid,
   input  logic [`MMU_LA_W-1:0]     req_addr,
   input  logic                     req_write,
   output logic                     rsp_valid,
   output logic [`MMU_PA_W-1:0]     rsp_paddr,
   output logic [1:0]               rsp_status  // mmu_pkg::xlat_status_e encoding
);

   mmu_cfg_if  cfg_bus ();
   mmu_xlat_if xlat_bus ();

   mmu_csr i_mmu_csr (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack   (wb_ack),
      .cfg      (cfg_bus.csr)
   );

   // Stage 1
   mmu_page_table i_mmu_page_table (
      .sysclk    (sysclk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_write (req_write),
      .cfg       (cfg_bus.tbl),
      .xo        (xlat_bus.src)
   );

   // Stage 2
   mmu_prot_check i_mmu_prot_check (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .xi         (xlat_bus.dst),
      .cfg        (cfg_bus.check),
      .rsp_valid  (rsp_valid),
      .rsp_paddr  (rsp_paddr),
      .rsp_status (rsp_status)
   );

endmodule

/* sim/mmu_tb.sv */
// MMU testbench; assumes a 2-cycle translation latency and an idle cycle after each Wishbone ack
`timescale 1ns/10ps
`include "mmu_consts.svh"

module mmu_tb;

   typedef struct packed {
      logic [`MMU_PA_W-1:0] paddr;
      logic [1:0]           status;
   } rsp_t;

   logic                     sysclk = 1'b0;
   logic                     rst_n;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   logic [`MMU_WB_ADR_W-1:0] wb_adr;
   logic [15:0]              wb_dat_i;
   logic [15:0]              wb_dat_o;
   logic                     wb_ack;
   logic                     req_valid;
   logic [`MMU_LA_W-1:0]     req_addr;
   logic                     req_write;
   logic                     rsp_valid;
   logic [`MMU_PA_W-1:0]     rsp_paddr;
   logic [1:0]               rsp_status;

   logic [15:0] table_model [0:`MMU_PAGES-1];  // Mirror of the page table
   logic        map_model;                     // Mirror of control bit 0
   rsp_t        expected [$];                  // Responses still in flight

   always #5 sysclk = ~sysclk;

   mmu_top i_mmu_top (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_i   (wb_dat_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack     (wb_ack),
      .req_valid  (req_valid),
      .req_addr   (req_addr),
      .req_write  (req_write),
      .rsp_valid  (rsp_valid),
      .rsp_paddr  (rsp_paddr),
      .rsp_status (rsp_status)
   );

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      assert (got === want) else begin
         stop_on_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want));
      end
   endtask

   // One classic cycle with the strobe held until the ack cycle
   task automatic wb_access(input logic we, input logic [`MMU_WB_ADR_W-1:0] adr,
                            input logic [15:0] wdata, output logic [15:0] rdata);
      int waited;
      @(negedge sysclk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_i = wdata;
      waited   = 0;
      do begin
         @(negedge sysclk);
         waited++;
      end while (!wb_ack && waited < 8);
      if (!wb_ack) begin
         stop_on_error("Wishbone access was never acknowledged");
      end
      rdata  = wb_dat_o;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [`MMU_WB_ADR_W-1:0] adr, input logic [15:0] data);
      logic [15:0] ignored;
      wb_access(1'b1, adr, data, ignored);
   endtask

   task automatic wb_read_check(input logic [`MMU_WB_ADR_W-1:0] adr, input logic [15:0] want);
      logic [15:0] data;
      wb_access(1'b0, adr, 16'h0000, data);
      check_value($sformatf("wb_dat_o at 0x%0h", adr), 32'(data), 32'(want));
   endtask

   // Expected result from the entry layout and the mapping rules
   function automatic rsp_t predict_response(input logic [15:0] addr, input logic write);
      rsp_t        r;
      logic [15:0] entry;
      entry = table_model[addr[15:10]];
      if (!map_model) begin
         r.paddr  = {8'h00, addr};
         r.status = mmu_pkg::XLAT_OK;
      end else begin
         r.paddr = {entry[13:0], addr[9:0]};
         if (!entry[15]) begin
            r.status = mmu_pkg::XLAT_INVALID;
         end else if (write && !entry[14]) begin
            r.status = mmu_pkg::XLAT_WPROT;
         end else begin
            r.status = mmu_pkg::XLAT_OK;
         end
      end
      return r;
   endfunction

   task automatic send_request(input logic [15:0] addr, input logic write);
      @(negedge sysclk);
      req_valid = 1'b1;
      req_addr  = addr;
      req_write = write;
      expected.push_back(predict_response(addr, write));
   endtask

   task automatic idle_request();
      @(negedge sysclk);
      req_valid = 1'b0;
      req_addr  = 16'($urandom);  // Junk address that must be ignored
      req_write = 1'b0;
   endtask

   task automatic run_traffic(input int count, input bit gaps);
      for (int i = 0; i < count; i++) begin
         if (gaps && $urandom_range(0, 3) == 0) begin
            idle_request();
         end
         send_request(16'($urandom), 1'($urandom));
      end
   endtask

   task automatic drain_responses();
      int waited;
      idle_request();
      waited = 0;
      while (expected.size() != 0 && waited < 10) begin
         @(negedge sysclk);
         waited++;
      end
      if (expected.size() != 0) begin
         stop_on_error("Expected responses never arrived");
      end
   endtask

   // Response scoreboard samples at the falling edge where outputs are stable
   always @(negedge sysclk) begin
      rsp_t want;
      if (rst_n && rsp_valid) begin
         if (expected.size() == 0) begin
            stop_on_error("rsp_valid came with no request in flight");
         end else begin
            want = expected.pop_front();
            check_value("rsp_paddr", 32'(rsp_paddr), 32'(want.paddr));
            check_value("rsp_status", 32'(rsp_status), 32'(want.status));
         end
      end
   end

   assert property (@(posedge sysclk) disable iff (!rst_n)
      (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
      else stop_on_error("wb_ack did not follow the strobe by one cycle");
   assert property (@(posedge sysclk) disable iff (!rst_n) wb_ack |=> !wb_ack)
      else stop_on_error("wb_ack stayed high for more than one cycle");
   assert property (@(posedge sysclk) disable iff (!rst_n) wb_ack |-> $past(wb_cyc && wb_stb))
      else stop_on_error("wb_ack rose without a strobe");
   assert property (@(posedge sysclk) disable iff (!rst_n) rsp_valid == $past(req_valid, 2))
      else stop_on_error("rsp_valid did not follow req_valid by exactly two cycles");

   initial begin
      void'($urandom(32'h44589db0));
      rst_n     = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_i  = 16'h0000;
      req_valid = 1'b0;
      req_addr  = 16'h0000;
      req_write = 1'b0;
      map_model = 1'b0;
      for (int i = 0; i <= 10; i++) begin
         @(negedge sysclk);
         check_value("rsp_valid", 32'(rsp_valid), 32'h0);
         check_value("wb_ack", 32'(wb_ack), 32'h0);
         if (i == 9) rst_n = 1'b1;  // Released after 10 cycles
      end
      wb_read_check(7'(`MMU_CSR_ADR), 16'h0000);

      // Fill the table, overwrite at random, then set three entries for each status
      for (int i = 0; i < `MMU_PAGES; i++) begin
         table_model[i] = 16'($urandom);
         wb_write(7'(i), table_model[i]);
      end
      for (int i = 0; i < 32; i++) begin
         int idx;
         idx = $urandom_range(0, `MMU_PAGES - 1);
         table_model[idx] = 16'($urandom);
         wb_write(7'(idx), table_model[idx]);
      end
      table_model[0] = 16'h2abc;  // Invalid
      table_model[1] = 16'h9a5c;  // Valid, read only
      table_model[2] = 16'hc3e1;  // Valid, writable
      for (int i = 0; i < 3; i++) wb_write(7'(i), table_model[i]);
      for (int i = 0; i < `MMU_PAGES; i++) wb_read_check(7'(i), table_model[i]);

      // Control register keeps bit 0 only
      wb_write(7'(`MMU_CSR_ADR), 16'hfffe);
      wb_read_check(7'(`MMU_CSR_ADR), 16'h0000);
      wb_write(7'(`MMU_CSR_ADR), 16'hffff);
      wb_read_check(7'(`MMU_CSR_ADR), 16'h0001);
      wb_write(7'(`MMU_CSR_ADR), 16'h0000);
      for (int i = 0; i < 8; i++) begin
         logic [`MMU_WB_ADR_W-1:0] adr;
         adr = 7'($urandom_range(`MMU_CSR_ADR + 1, 127));
         wb_write(adr, 16'($urandom));
         wb_read_check(adr, 16'h0000);
      end

      // Address passes straight through while mapping is off
      map_model = 1'b0;
      run_traffic(100, 1'b1);
      drain_responses();

      // Directed faults first once mapping is on
      wb_write(7'(`MMU_CSR_ADR), 16'h0001);
      map_model = 1'b1;
      send_request({6'd0, 10'h155}, 1'b0);
      send_request({6'd1, 10'h2aa}, 1'b1);
      send_request({6'd1, 10'h0f0}, 1'b0);
      send_request({6'd2, 10'h3ff}, 1'b1);
      run_traffic(200, 1'b1);
      drain_responses();

      // Back-to-back requests keep two in flight
      run_traffic(40, 1'b0);
      drain_responses();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* sources.f */
+incdir+logic
logic/mmu_pkg.sv
logic/mmu_if.sv
logic/mmu_csr.sv
logic/mmu_page_table.sv
logic/mmu_prot_check.sv
logic/mmu_top.sv
sim/mmu_tb.sv
